/* common/dds_pkg.sv */
// DDS sample path definitions
`default_nettype none

package dds_pkg;

  // default widths and counts, the top level passes its own values down
  localparam int PHASE_BITS       = 24;
  localparam int SAMPLE_WIDTH     = 16;
  localparam int QUANT_BITS       = 8;
  localparam int PARALLEL_SAMPLES = 4;
  localparam int CHANNELS         = 8;

  localparam real PI = 3.14159265358979323846;

  // phase accumulator value, also used for the per-channel increment
  typedef logic [PHASE_BITS-1:0] phase_t;

  // one signed cosine sample
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // cosine table entry for address q
  // the table spans one full period over 2**qbits addresses
  // amplitude is the largest positive value of a swidth-bit signed sample
  // the int cast rounds to nearest, so the result is exact for the testbench too
  function automatic int cos_entry(input int q,
                                   input int qbits  = QUANT_BITS,
                                   input int swidth = SAMPLE_WIDTH);
    real amp;
    real angle;
    amp   = real'((longint'(1) << (swidth - 1)) - 1);
    angle = 2.0 * PI * real'(q) / (2.0 ** qbits);
    return int'(amp * $cos(angle));
  endfunction

endpackage

`default_nettype wire

/* common/cfg_pkg.sv */
// DDS configuration path definitions
`default_nettype none

package cfg_pkg;

  import dds_pkg::*;

  // depth of the config buffer, which is also the sender's initial credit count
  localparam int CFG_DEPTH = 4;

  // index bits into the config buffer, the pointers carry one extra wrap bit
  localparam int CFG_PTR_BITS = $clog2(CFG_DEPTH);

  // channel index carried with every config write
  typedef logic [$clog2(CHANNELS)-1:0] chan_idx_t;

  // one buffered config write, channel in the upper bits and increment below
  typedef struct packed {
    chan_idx_t chan;
    phase_t    inc;
  } cfg_entry_t;

endpackage

`default_nettype wire

/* dds/dds_phase_accum.sv */
// DDS phase accumulators
`timescale 1ns/1ps
`default_nettype none

module dds_phase_accum
  import dds_pkg::*;
#(
  parameter int CHANNELS         = dds_pkg::CHANNELS,
  parameter int PARALLEL_SAMPLES = dds_pkg::PARALLEL_SAMPLES,
  parameter int PHASE_BITS       = dds_pkg::PHASE_BITS
) (
  input  wire logic                                            ps_clk,
  input  wire logic                                            arst_n,
  input  wire logic [CHANNELS*PHASE_BITS-1:0]                  inc_bus,
  output logic      [CHANNELS*PARALLEL_SAMPLES*PHASE_BITS-1:0] phase_bus,
  output logic                                                 phase_valid
);

  // phases are valid from the first edge after reset, since every
  // accumulator starts at zero and the lane registers load on that edge
  always_ff @(posedge ps_clk or negedge arst_n) begin
    if (!arst_n) begin
      phase_valid <= 1'b0;
    end else begin
      phase_valid <= 1'b1;
    end
  end

  for (genvar c = 0; c < CHANNELS; c++) begin : g_chan
    logic [PHASE_BITS-1:0] inc;
    logic [PHASE_BITS-1:0] step;
    logic [PHASE_BITS-1:0] base_q;

    assign inc = inc_bus[c*PHASE_BITS +: PHASE_BITS];

    // one cycle covers PARALLEL_SAMPLES output samples
    // the product wraps at PHASE_BITS, like the accumulator itself
    assign step = inc * PHASE_BITS'(PARALLEL_SAMPLES);

    // base phase of lane 0 for the next cycle
    always_ff @(posedge ps_clk or negedge arst_n) begin
      if (!arst_n) begin
        base_q <= '0;
      end else begin
        base_q <= base_q + step;
      end
    end

    // lane k sits k increments past the base
    // a new increment shows up here on the edge after it was applied,
    // while the base it adds to still holds the old advance
    for (genvar k = 0; k < PARALLEL_SAMPLES; k++) begin : g_lane
      logic [PHASE_BITS-1:0] phase_q;

      always_ff @(posedge ps_clk) begin
        phase_q <= base_q + inc * PHASE_BITS'(k);
      end

      // channel outermost, lane inner
      assign phase_bus[(c*PARALLEL_SAMPLES + k)*PHASE_BITS +: PHASE_BITS] = phase_q;
    end
  end

endmodule

`default_nettype wire

/* dds/dds_cos_lut.sv */
// DDS cosine table lookup
`timescale 1ns/1ps
`default_nettype none

module dds_cos_lut
  import dds_pkg::*;
#(
  parameter int CHANNELS         = dds_pkg::CHANNELS,
  parameter int PARALLEL_SAMPLES = dds_pkg::PARALLEL_SAMPLES,
  parameter int PHASE_BITS       = dds_pkg::PHASE_BITS,
  parameter int QUANT_BITS       = dds_pkg::QUANT_BITS,
  parameter int SAMPLE_WIDTH     = dds_pkg::SAMPLE_WIDTH
) (
  input  wire logic                                              ps_clk,
  input  wire logic                                              arst_n,
  input  wire logic [CHANNELS*PARALLEL_SAMPLES*PHASE_BITS-1:0]   phase_bus,
  input  wire logic                                              phase_valid,
  output logic      [CHANNELS*PARALLEL_SAMPLES*SAMPLE_WIDTH-1:0] samples,
  output logic                                                   samples_valid
);

  localparam int DEPTH = 2 ** QUANT_BITS;
  localparam int LANES = CHANNELS * PARALLEL_SAMPLES;

  // full-wave cosine table, every entry is a constant fixed at elaboration
  logic [SAMPLE_WIDTH-1:0] cos_rom [DEPTH];

  for (genvar q = 0; q < DEPTH; q++) begin : g_rom
    assign cos_rom[q] = SAMPLE_WIDTH'(cos_entry(q, QUANT_BITS, SAMPLE_WIDTH));
  end

  // valid follows the phase register by the single lookup stage
  always_ff @(posedge ps_clk or negedge arst_n) begin
    if (!arst_n) begin
      samples_valid <= 1'b0;
    end else begin
      samples_valid <= phase_valid;
    end
  end

  // the bus order of phases and samples is the same, channel outermost and
  // lane inner, so one flat lane index serves both sides
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    logic [QUANT_BITS-1:0]   addr;
    logic [SAMPLE_WIDTH-1:0] sample_q;

    // plain truncation, the low phase bits are dropped without dither
    assign addr = phase_bus[i*PHASE_BITS + PHASE_BITS - QUANT_BITS +: QUANT_BITS];

    // registered table read, all lanes look up in parallel
    always_ff @(posedge ps_clk) begin
      sample_q <= cos_rom[addr];
    end

    assign samples[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = sample_q;
  end

endmodule

`default_nettype wire

/* dds/dds.sv */
// DDS synthesizer core
`timescale 1ns/1ps
`default_nettype none

module dds
  import dds_pkg::*;
#(
  parameter int CHANNELS         = dds_pkg::CHANNELS,
  parameter int PARALLEL_SAMPLES = dds_pkg::PARALLEL_SAMPLES,
  parameter int PHASE_BITS       = dds_pkg::PHASE_BITS,
  parameter int QUANT_BITS       = dds_pkg::QUANT_BITS,
  parameter int SAMPLE_WIDTH     = dds_pkg::SAMPLE_WIDTH
) (
  input  wire logic                                              ps_clk,
  input  wire logic                                              arst_n,
  input  wire logic [CHANNELS*PHASE_BITS-1:0]                    inc_bus,
  output logic      [CHANNELS*PARALLEL_SAMPLES*SAMPLE_WIDTH-1:0] samples,
  output logic                                                   samples_valid
);

  // registered lane phases between the two stages
  logic [CHANNELS*PARALLEL_SAMPLES*PHASE_BITS-1:0] phase_bus;
  logic                                            phase_valid;

  // stage one advances every channel and spreads its lanes
  dds_phase_accum #(
    .CHANNELS         (CHANNELS),
    .PARALLEL_SAMPLES (PARALLEL_SAMPLES),
    .PHASE_BITS       (PHASE_BITS)
  ) u_phase_accum (
    .ps_clk      (ps_clk),
    .arst_n      (arst_n),
    .inc_bus     (inc_bus),
    .phase_bus   (phase_bus),
    .phase_valid (phase_valid)
  );

  // stage two turns phases into samples
  // the valid flag rides through both stages next to the data, so it
  // stays aligned with the samples it marks
  dds_cos_lut #(
    .CHANNELS         (CHANNELS),
    .PARALLEL_SAMPLES (PARALLEL_SAMPLES),
    .PHASE_BITS       (PHASE_BITS),
    .QUANT_BITS       (QUANT_BITS),
    .SAMPLE_WIDTH     (SAMPLE_WIDTH)
  ) u_cos_lut (
    .ps_clk        (ps_clk),
    .arst_n        (arst_n),
    .phase_bus     (phase_bus),
    .phase_valid   (phase_valid),
    .samples       (samples),
    .samples_valid (samples_valid)
  );

endmodule

`default_nettype wire

/* rtl/phase_inc_regs.sv */
// DDS phase increment registers
`timescale 1ns/1ps
`default_nettype none

module phase_inc_regs
  import dds_pkg::*;
  import cfg_pkg::*;
#(
  parameter int CHANNELS   = dds_pkg::CHANNELS,
  parameter int PHASE_BITS = dds_pkg::PHASE_BITS
) (
  input  wire logic                           ps_clk,
  input  wire logic                           arst_n,
  input  wire logic                           cfg_valid,
  input  wire chan_idx_t                      cfg_chan,
  input  wire phase_t                         cfg_inc,
  output logic                                cfg_credit,
  output logic      [CHANNELS*PHASE_BITS-1:0] inc_bus
);

  // buffer storage, payload only
  cfg_entry_t fifo_mem [CFG_DEPTH];

  // pointers with one wrap bit so full and empty can be told apart
  logic [CFG_PTR_BITS:0] wr_ptr;
  logic [CFG_PTR_BITS:0] rd_ptr;
  logic                  fifo_empty;
  cfg_entry_t            head;

  // high in the cycle after an entry was applied
  logic apply_q;

  assign fifo_empty = (wr_ptr == rd_ptr);
  assign head       = fifo_mem[rd_ptr[CFG_PTR_BITS-1:0]];

  // the sender spends a credit per write, so a write always finds a free slot
  always_ff @(posedge ps_clk) begin
    if (cfg_valid) begin
      fifo_mem[wr_ptr[CFG_PTR_BITS-1:0]] <= '{chan: cfg_chan, inc: cfg_inc};
    end
  end

  // the head entry is applied on the first edge after it was written,
  // one entry per cycle in arrival order
  // the credit comes one cycle after the apply edge, so its pulse ends on
  // the edge that registers the first samples with the new increment
  always_ff @(posedge ps_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      apply_q    <= 1'b0;
      cfg_credit <= 1'b0;
    end else begin
      if (cfg_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (!fifo_empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      apply_q    <= !fifo_empty;
      cfg_credit <= apply_q;
    end
  end

  for (genvar c = 0; c < CHANNELS; c++) begin : g_chan
    logic [PHASE_BITS-1:0] inc_q;

    // a later write to the same channel simply overwrites on its own turn
    always_ff @(posedge ps_clk or negedge arst_n) begin
      if (!arst_n) begin
        inc_q <= '0;
      end else if (!fifo_empty && head.chan == chan_idx_t'(c)) begin
        inc_q <= head.inc;
      end
    end

    assign inc_bus[c*PHASE_BITS +: PHASE_BITS] = inc_q;
  end

endmodule

`default_nettype wire

/* rtl/dds_top.sv */
// DDS top level
`timescale 1ns/1ps
`default_nettype none

module dds_top
  import dds_pkg::*;
  import cfg_pkg::*;
#(
  parameter int CHANNELS         = dds_pkg::CHANNELS,
  parameter int PARALLEL_SAMPLES = dds_pkg::PARALLEL_SAMPLES,
  parameter int PHASE_BITS       = dds_pkg::PHASE_BITS,
  parameter int QUANT_BITS       = dds_pkg::QUANT_BITS,
  parameter int SAMPLE_WIDTH     = dds_pkg::SAMPLE_WIDTH
) (
  input  wire logic                                              ps_clk,
  input  wire logic                                              arst_n,
  input  wire logic                                              cfg_valid,
  input  wire chan_idx_t                                         cfg_chan,
  input  wire phase_t                                            cfg_inc,
  output logic                                                   cfg_credit,
  output logic      [CHANNELS*PARALLEL_SAMPLES*SAMPLE_WIDTH-1:0] samples,
  output logic                                                   samples_valid
);

  // current increment of every channel
  logic [CHANNELS*PHASE_BITS-1:0] inc_bus;

  // config writes land here and return credits as they are applied
  phase_inc_regs #(
    .CHANNELS   (CHANNELS),
    .PHASE_BITS (PHASE_BITS)
  ) u_phase_inc_regs (
    .ps_clk     (ps_clk),
    .arst_n     (arst_n),
    .cfg_valid  (cfg_valid),
    .cfg_chan   (cfg_chan),
    .cfg_inc    (cfg_inc),
    .cfg_credit (cfg_credit),
    .inc_bus    (inc_bus)
  );

  dds #(
    .CHANNELS         (CHANNELS),
    .PARALLEL_SAMPLES (PARALLEL_SAMPLES),
    .PHASE_BITS       (PHASE_BITS),
    .QUANT_BITS       (QUANT_BITS),
    .SAMPLE_WIDTH     (SAMPLE_WIDTH)
  ) u_dds (
    .ps_clk        (ps_clk),
    .arst_n        (arst_n),
    .inc_bus       (inc_bus),
    .samples       (samples),
    .samples_valid (samples_valid)
  );

endmodule

`default_nettype wire

/* testbench/dds_tb.sv */
// DDS testbench
`timescale 1ns/1ps
`default_nettype none

module dds_tb
  import dds_pkg::*;
  import cfg_pkg::*;
();

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 16;
  localparam int SETTLE_CYCLES = 300;
  localparam int RAND_WRITES   = 48;
  localparam int MAX_GAP       = 20;
  localparam int BURSTS        = 4;
  localparam int FLOOD_WRITES  = 24;
  // cycles the flood sender sits on each returned credit before it may spend it
  localparam int FLOOD_HOLD    = 2;
  // every phase is bounded, a write costs its gap plus a few cycles of credit wait
  localparam int TEST_CYCLES   = RESET_CYCLES + 20 + CHANNELS * 4 + 2 * SETTLE_CYCLES +
                                 RAND_WRITES * (MAX_GAP + 4) + BURSTS * (2 * CFG_DEPTH + 24) +
                                 FLOOD_WRITES * 4;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 500;

  logic                                          ps_clk;
  logic                                          arst_n;
  logic                                          cfg_valid;
  chan_idx_t                                     cfg_chan;
  phase_t                                        cfg_inc;
  logic                                          cfg_credit;
  logic [CHANNELS*PARALLEL_SAMPLES*SAMPLE_WIDTH-1:0] samples;
  logic                                          samples_valid;

  integer    seed;
  int        edge_cnt;
  int        credits;
  int        hold_cycles;
  int        stall_count;
  int        burst_count;
  int        last_credit_edge;
  logic      in_burst;
  // writes that are sent but not yet credited, in arrival order
  chan_idx_t q_chan [$];
  phase_t    q_inc [$];
  // edges at which held credits become spendable again
  int        credit_hold [$];
  // model state, m_base is the base phase after the previous edge and
  // m_phase the lane phases registered on it
  phase_t    m_inc [CHANNELS];
  phase_t    m_base [CHANNELS];
  phase_t    m_phase [CHANNELS][PARALLEL_SAMPLES];

  dds_top DUT (
    .ps_clk        (ps_clk),
    .arst_n        (arst_n),
    .cfg_valid     (cfg_valid),
    .cfg_chan      (cfg_chan),
    .cfg_inc       (cfg_inc),
    .cfg_credit    (cfg_credit),
    .samples       (samples),
    .samples_valid (samples_valid)
  );

  always #(CLK_PERIOD / 2) ps_clk = ~ps_clk;

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_sample(input sample_t got, input sample_t exp, input int c, input int k);
    if (got !== exp) begin
      fail_now($sformatf("Error: samples[ch %0d][lane %0d] got 0x%h expected 0x%h",
                         c, k, got, exp));
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("Error: samples_valid got 0x%h expected 0x%h", got, exp));
    end
  endtask

  task automatic check_credit(input logic credit);
    if (credit === 1'b1) begin
      // with nothing outstanding this credit would lift the count above the buffer depth
      if (q_chan.size() == 0) begin
        fail_now("a credit came back while no write was outstanding");
      end else if (in_burst && burst_count > 0 && edge_cnt != last_credit_edge + 1) begin
        fail_now("the credits of a burst did not return on consecutive cycles");
      end
    end else if (credit !== 1'b0) begin
      fail_now($sformatf("Error: cfg_credit got 0x%h expected 0x0", credit));
    end
  endtask

  // one clock edge of the model, called once the DUT outputs have settled
  task automatic model_step();
    chan_idx_t             ch;
    logic [QUANT_BITS-1:0] addr;
    edge_cnt++;
    // the lookup sits one stage behind the phases, so valid needs two edges
    check_valid(samples_valid, edge_cnt >= 2);
    if (edge_cnt >= 2) begin
      for (int c = 0; c < CHANNELS; c++) begin
        for (int k = 0; k < PARALLEL_SAMPLES; k++) begin
          addr = m_phase[c][k][PHASE_BITS-1 -: QUANT_BITS];
          check_sample(
            sample_t'(samples[(c * PARALLEL_SAMPLES + k) * SAMPLE_WIDTH +: SAMPLE_WIDTH]),
            sample_t'(cos_entry(int'(addr), QUANT_BITS, SAMPLE_WIDTH)), c, k);
        end
      end
    end
    check_credit(cfg_credit);
    // a credit now means its increment was applied one edge earlier,
    // so it already sets the lane offsets registered on this edge
    if (cfg_credit) begin
      ch        = q_chan.pop_front();
      m_inc[ch] = q_inc.pop_front();
      if (hold_cycles > 0) begin
        credit_hold.push_back(edge_cnt + hold_cycles);
      end else begin
        credits++;
      end
      if (in_burst) begin
        burst_count++;
      end
      last_credit_edge = edge_cnt;
    end
    while (credit_hold.size() != 0 && credit_hold[0] <= edge_cnt) begin
      void'(credit_hold.pop_front());
      credits++;
    end
    for (int c = 0; c < CHANNELS; c++) begin
      for (int k = 0; k < PARALLEL_SAMPLES; k++) begin
        m_phase[c][k] = m_base[c] + m_inc[c] * phase_t'(k);
      end
      m_base[c] = m_base[c] + m_inc[c] * phase_t'(PARALLEL_SAMPLES);
    end
  endtask

  task automatic step_cycle();
    @(negedge ps_clk);
    model_step();
    cfg_valid = 1'b0;
  endtask

  task automatic send_write(input chan_idx_t ch, input phase_t inc);
    // with no credit left the sender idles until one is spendable
    while (credits == 0) begin
      stall_count++;
      step_cycle();
    end
    cfg_valid = 1'b1;
    cfg_chan  = ch;
    cfg_inc   = inc;
    q_chan.push_back(ch);
    q_inc.push_back(inc);
    credits--;
    step_cycle();
  endtask

  task automatic drain();
    while (q_chan.size() != 0 || credit_hold.size() != 0) begin
      step_cycle();
    end
  endtask

  function automatic chan_idx_t rand_chan();
    return chan_idx_t'($unsigned($random(seed)) % CHANNELS);
  endfunction

  // 0 gives any increment, 1 a slow tone, 2 one close to half the phase range
  function automatic phase_t rand_inc(input int kind);
    case (kind)
      0:       return phase_t'($random(seed));
      1:       return phase_t'($unsigned($random(seed)) % 4096);
      default: return phase_t'((1 << (PHASE_BITS - 1)) + ($random(seed) % 64));
    endcase
  endfunction

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_now("watchdog timeout, the tests did not finish in time");
  end

  initial begin
    chan_idx_t first;
    seed             = 92;
    ps_clk           = 1'b0;
    arst_n           = 1'b0;
    cfg_valid        = 1'b0;
    cfg_chan         = '0;
    cfg_inc          = '0;
    edge_cnt         = 0;
    credits          = CFG_DEPTH;
    hold_cycles      = 0;
    stall_count      = 0;
    burst_count      = 0;
    last_credit_edge = 0;
    in_burst         = 1'b0;
    for (int c = 0; c < CHANNELS; c++) begin
      m_inc[c]  = '0;
      m_base[c] = '0;
      for (int k = 0; k < PARALLEL_SAMPLES; k++) begin
        m_phase[c][k] = '0;
      end
    end
    repeat (RESET_CYCLES) @(negedge ps_clk);
    check_valid(samples_valid, 1'b0);
    check_credit(cfg_credit);
    arst_n = 1'b1;

    // zero increments, so every lane holds cos_entry(0) and no credit moves
    repeat (20) step_cycle();

    // one tone per channel, then a long steady run
    for (int c = 0; c < CHANNELS; c++) begin
      send_write(chan_idx_t'(c), rand_inc(0) | phase_t'(1));
    end
    drain();
    repeat (SETTLE_CYCLES) step_cycle();

    // random tones of all three kinds with random gaps
    repeat (RAND_WRITES) begin
      send_write(rand_chan(), rand_inc(int'($unsigned($random(seed)) % 3)));
      repeat (int'($unsigned($random(seed)) % (MAX_GAP + 1))) step_cycle();
    end
    drain();

    // full-depth bursts, the last write hits the first one's channel again
    repeat (BURSTS) begin
      first       = rand_chan();
      in_burst    = 1'b1;
      burst_count = 0;
      for (int i = 0; i < CFG_DEPTH; i++) begin
        send_write((i == 0 || i == CFG_DEPTH - 1) ? first : rand_chan(),
                   rand_inc(int'($unsigned($random(seed)) % 3)));
      end
      drain();
      in_burst = 1'b0;
      repeat (20) step_cycle();
    end

    // a slow credit path makes the flood sender run dry and wait
    hold_cycles = FLOOD_HOLD;
    stall_count = 0;
    repeat (FLOOD_WRITES) begin
      send_write(rand_chan(), rand_inc(int'($unsigned($random(seed)) % 3)));
    end
    drain();
    hold_cycles = 0;
    if (stall_count == 0) begin
      fail_now("the flood sender never ran out of credits");
    end
    repeat (SETTLE_CYCLES) step_cycle();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
common/dds_pkg.sv
common/cfg_pkg.sv
dds/dds_phase_accum.sv
dds/dds_cos_lut.sv
dds/dds.sv
rtl/phase_inc_regs.sv
rtl/dds_top.sv
testbench/dds_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dds_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation completed successfully

SRCS := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
